// ==== alu_execute.sv ====
module alu_execute
    import mips_isa_pkg::*;
(
    input  logic [ALU_OP_W-1:0] i_alu_op,
    input  logic [DWORD-1:0]    i_a,
    input  logic [DWORD-1:0]    i_b,
    input  logic [SHAMT_W-1:0]  i_shamt,
    output logic [DWORD-1:0]    o_result
);

    logic slt_bit;

    // signed compare for slt/slti
    assign slt_bit = $signed(i_a) < $signed(i_b);

    always_comb begin
        case (i_alu_op)
            ALU_ADD: o_result = i_a + i_b;
            ALU_SUB: o_result = i_a - i_b;
            ALU_AND: o_result = i_a & i_b;
            ALU_OR:  o_result = i_a | i_b;
            ALU_XOR: o_result = i_a ^ i_b;
            ALU_SLT: o_result = {{(DWORD-1){1'b0}}, slt_bit};
            // shifts act on rt, amount from the shamt field
            ALU_SLL: o_result = i_b << i_shamt;
            ALU_SRL: o_result = i_b >> i_shamt;
            // immediate into upper half, lower half zero
            ALU_LUI: o_result = {i_b[15:0], 16'h0000};
            default: o_result = '0;
        endcase
    end

endmodule

// ==== data_path.sv ====
module data_path
    import mips_isa_pkg::*;
(
    input  logic               i_clock,
    input  logic               i_rst_n,
    input  logic               i_core_enable,
    input  logic               i_pc_clear,
    input  logic               i_im_write_enable,
    input  logic [IM_ADDR-1:0] i_im_addr,
    input  logic [DWORD-1:0]   i_im_data,
    input  logic [RB_ADDR-1:0] i_rb_addr,
    output logic               o_halted,
    output logic [DWORD-1:0]   o_pc_value,
    output logic [DWORD-1:0]   o_rb_data
);

    logic [DWORD-1:0]    pc;
    logic [DWORD-1:0]    im_rdata;
    instr_u              instr;
    logic [RB_ADDR-1:0]  rs;
    logic [RB_ADDR-1:0]  rt;
    logic [RB_ADDR-1:0]  rd_dest;
    logic [DWORD-1:0]    imm_ext;
    logic                use_imm;
    logic [ALU_OP_W-1:0] alu_op;
    logic                reg_write;
    logic                halt;
    logic [DWORD-1:0]    op_a;
    logic [DWORD-1:0]    op_b;
    logic [DWORD-1:0]    alu_b;
    logic [DWORD-1:0]    alu_result;
    logic                wb_we;
    logic [RB_ADDR-1:0]  wb_addr;
    logic [DWORD-1:0]    wb_data;

    // pc holds on the halt address
    always_ff @(posedge i_clock) begin
        if (!i_rst_n || i_pc_clear) begin
            pc <= '0;
        end else if (i_core_enable && !halt && !o_halted) begin
            pc <= pc + 32'd4;
        end
    end

    assign o_pc_value = pc;
    assign instr      = im_rdata;
    // rt or immediate into the alu
    assign alu_b      = use_imm ? imm_ext : op_b;

    instr_memory instr_memory_inst (
        .i_clock (i_clock),
        .i_we    (i_im_write_enable),
        .i_waddr (i_im_addr),
        .i_wdata (i_im_data),
        // byte pc to word index
        .i_raddr (pc[IM_ADDR+1:2]),
        .o_rdata (im_rdata)
    );

    instr_decoder instr_decoder_inst (
        .i_instr     (instr),
        .o_rs        (rs),
        .o_rt        (rt),
        .o_rd_dest   (rd_dest),
        .o_imm_ext   (imm_ext),
        .o_use_imm   (use_imm),
        .o_alu_op    (alu_op),
        .o_reg_write (reg_write),
        .o_halt      (halt)
    );

    register_bank register_bank_inst (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_we       (wb_we),
        .i_waddr    (wb_addr),
        .i_wdata    (wb_data),
        .i_ra       (rs),
        .i_rb       (rt),
        .i_dbg_addr (i_rb_addr),
        .o_a        (op_a),
        .o_b        (op_b),
        .o_dbg      (o_rb_data)
    );

    alu_execute alu_execute_inst (
        .i_alu_op (alu_op),
        .i_a      (op_a),
        .i_b      (alu_b),
        .i_shamt  (instr.r_fmt.shamt),
        .o_result (alu_result)
    );

    result_writeback result_writeback_inst (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_enable    (i_core_enable),
        .i_clear     (i_pc_clear),
        .i_reg_write (reg_write),
        .i_halt      (halt),
        .i_dest      (rd_dest),
        .i_result    (alu_result),
        .o_we        (wb_we),
        .o_waddr     (wb_addr),
        .o_wdata     (wb_data),
        .o_halted    (o_halted)
    );

    // program load and execution never overlap
    a_no_load_while_run: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        !(i_im_write_enable && i_core_enable));

endmodule

// ==== debug_pkg.sv ====
package debug_pkg;

    // command bytes from the host
    localparam logic [7:0] CMD_LOAD     = 8'h01;
    localparam logic [7:0] CMD_RUN      = 8'h02;
    localparam logic [7:0] CMD_STEP     = 8'h03;
    localparam logic [7:0] CMD_READ_REG = 8'h04;
    localparam logic [7:0] CMD_READ_PC  = 8'h05;
    localparam logic [7:0] CMD_CLEAR    = 8'h06;

    // last word of a program load
    localparam logic [31:0] HALT_WORD = 32'hFFFF_FFFF;

    // debug fsm states
    localparam int DBG_ST_W = 3;
    localparam logic [DBG_ST_W-1:0] DBG_ST_IDLE    = 3'd0;
    localparam logic [DBG_ST_W-1:0] DBG_ST_LOAD    = 3'd1;
    localparam logic [DBG_ST_W-1:0] DBG_ST_LOAD_WR = 3'd2;
    localparam logic [DBG_ST_W-1:0] DBG_ST_RUN     = 3'd3;
    localparam logic [DBG_ST_W-1:0] DBG_ST_REG_IDX = 3'd4;
    localparam logic [DBG_ST_W-1:0] DBG_ST_TX      = 3'd5;

endpackage

// ==== debug_unit.sv ====
module debug_unit
    import mips_isa_pkg::*;
    import debug_pkg::*;
(
    input  logic               i_clock,
    input  logic               i_rst_n,
    input  logic [BYTE-1:0]    i_rx_data,
    input  logic               i_rx_done,
    input  logic               i_tx_done,
    input  logic               i_halted,
    input  logic [DWORD-1:0]   i_pc_value,
    input  logic [DWORD-1:0]   i_rb_data,
    output logic [BYTE-1:0]    o_tx_data,
    output logic               o_tx_start,
    output logic               o_im_write_enable,
    output logic [IM_ADDR-1:0] o_im_addr,
    output logic [DWORD-1:0]   o_im_data,
    output logic               o_core_enable,
    output logic               o_pc_clear,
    output logic [RB_ADDR-1:0] o_rb_addr
);

    logic [DBG_ST_W-1:0] state;
    logic [1:0]          byte_cnt;
    logic [DWORD-1:0]    shift_word;
    logic                tx_sel_pc;
    logic [DWORD-1:0]    tx_word;

    // reply source, picked per command
    assign tx_word   = tx_sel_pc ? i_pc_value : i_rb_data;
    // lsb first, byte_cnt walks the word
    assign o_tx_data = tx_word[byte_cnt*BYTE +: BYTE];
    assign o_im_data = shift_word;

    // load word assembly, new byte enters at the top
    always_ff @(posedge i_clock) begin
        if (state == DBG_ST_LOAD && i_rx_done) begin
            shift_word <= {i_rx_data, shift_word[DWORD-1:BYTE]};
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state             <= DBG_ST_IDLE;
            byte_cnt          <= '0;
            tx_sel_pc         <= 1'b0;
            o_tx_start        <= 1'b0;
            o_im_write_enable <= 1'b0;
            o_im_addr         <= '0;
            o_core_enable     <= 1'b0;
            o_pc_clear        <= 1'b0;
            o_rb_addr         <= '0;
        end else begin
            // one-cycle strobes
            o_tx_start        <= 1'b0;
            o_im_write_enable <= 1'b0;
            o_pc_clear        <= 1'b0;
            o_core_enable     <= 1'b0;
            case (state)
                DBG_ST_IDLE: begin
                    if (i_rx_done) begin
                        case (i_rx_data)
                            CMD_LOAD: begin
                                state     <= DBG_ST_LOAD;
                                byte_cnt  <= '0;
                                o_im_addr <= '0;
                            end
                            CMD_RUN: begin
                                state         <= DBG_ST_RUN;
                                o_core_enable <= 1'b1;
                            end
                            // single enable pulse
                            CMD_STEP: o_core_enable <= !i_halted;
                            CMD_READ_REG: state <= DBG_ST_REG_IDX;
                            CMD_READ_PC: begin
                                tx_sel_pc  <= 1'b1;
                                byte_cnt   <= '0;
                                o_tx_start <= 1'b1;
                                state      <= DBG_ST_TX;
                            end
                            CMD_CLEAR: o_pc_clear <= 1'b1;
                            default: state <= DBG_ST_IDLE;
                        endcase
                    end
                end
                DBG_ST_LOAD: begin
                    if (i_rx_done) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        // fourth byte completes the word
                        if (byte_cnt == 2'd3) begin
                            o_im_write_enable <= 1'b1;
                            state             <= DBG_ST_LOAD_WR;
                        end
                    end
                end
                DBG_ST_LOAD_WR: begin
                    o_im_addr <= o_im_addr + 1'b1;
                    // halt word ends the program
                    state <= (shift_word == HALT_WORD) ? DBG_ST_IDLE : DBG_ST_LOAD;
                end
                DBG_ST_RUN: begin
                    if (i_halted) begin
                        state <= DBG_ST_IDLE;
                    end else begin
                        o_core_enable <= 1'b1;
                    end
                end
                DBG_ST_REG_IDX: begin
                    if (i_rx_done) begin
                        o_rb_addr  <= i_rx_data[RB_ADDR-1:0];
                        tx_sel_pc  <= 1'b0;
                        byte_cnt   <= '0;
                        o_tx_start <= 1'b1;
                        state      <= DBG_ST_TX;
                    end
                end
                DBG_ST_TX: begin
                    // done during the start pulse is not for the next byte
                    if (i_tx_done && !o_tx_start) begin
                        if (byte_cnt == 2'd3) begin
                            state <= DBG_ST_IDLE;
                        end else begin
                            byte_cnt   <= byte_cnt + 2'd1;
                            o_tx_start <= 1'b1;
                        end
                    end
                end
                default: state <= DBG_ST_IDLE;
            endcase
        end
    end

    // each byte gets its own start pulse
    a_tx_start_pulse: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_tx_start |=> !o_tx_start);

endmodule

// ==== instr_decoder.sv ====
module instr_decoder
    import mips_isa_pkg::*;
(
    input  instr_u              i_instr,
    output logic [RB_ADDR-1:0]  o_rs,
    output logic [RB_ADDR-1:0]  o_rt,
    output logic [RB_ADDR-1:0]  o_rd_dest,
    output logic [DWORD-1:0]    o_imm_ext,
    output logic                o_use_imm,
    output logic [ALU_OP_W-1:0] o_alu_op,
    output logic                o_reg_write,
    output logic                o_halt
);

    logic [DWORD-1:0] imm_sext;
    logic [DWORD-1:0] imm_zext;

    // rs/rt sit at the same bits in both formats
    assign o_rs = i_instr.r_fmt.rs;
    assign o_rt = i_instr.r_fmt.rt;

    assign imm_sext = {{16{i_instr.i_fmt.imm16[15]}}, i_instr.i_fmt.imm16};
    assign imm_zext = {16'h0000, i_instr.i_fmt.imm16};

    always_comb begin
        // unknown encodings fall through as no-write
        o_alu_op    = ALU_ADD;
        o_use_imm   = 1'b1;
        o_imm_ext   = imm_zext;
        o_reg_write = 1'b0;
        o_halt      = 1'b0;
        o_rd_dest   = i_instr.i_fmt.rt;
        case (i_instr.r_fmt.opcode)
            OP_RTYPE: begin
                o_use_imm   = 1'b0;
                o_rd_dest   = i_instr.r_fmt.rd;
                o_reg_write = 1'b1;
                case (i_instr.r_fmt.funct)
                    FN_ADDU: o_alu_op = ALU_ADD;
                    FN_SUBU: o_alu_op = ALU_SUB;
                    FN_AND:  o_alu_op = ALU_AND;
                    FN_OR:   o_alu_op = ALU_OR;
                    FN_XOR:  o_alu_op = ALU_XOR;
                    FN_SLT:  o_alu_op = ALU_SLT;
                    FN_SLL:  o_alu_op = ALU_SLL;
                    FN_SRL:  o_alu_op = ALU_SRL;
                    default: o_reg_write = 1'b0;
                endcase
            end
            // arithmetic immediates are signed
            OP_ADDIU: begin
                o_imm_ext   = imm_sext;
                o_reg_write = 1'b1;
            end
            OP_SLTI: begin
                o_imm_ext   = imm_sext;
                o_alu_op    = ALU_SLT;
                o_reg_write = 1'b1;
            end
            // logic immediates zero-extended
            OP_ANDI: begin
                o_alu_op    = ALU_AND;
                o_reg_write = 1'b1;
            end
            OP_ORI: begin
                o_alu_op    = ALU_OR;
                o_reg_write = 1'b1;
            end
            OP_XORI: begin
                o_alu_op    = ALU_XOR;
                o_reg_write = 1'b1;
            end
            OP_LUI: begin
                o_alu_op    = ALU_LUI;
                o_reg_write = 1'b1;
            end
            OP_HALT: o_halt = 1'b1;
            default: o_reg_write = 1'b0;
        endcase
    end

    // a halt must never also update the register file
    always_comb begin
        assert final (!(o_halt && o_reg_write));
    end

endmodule

// ==== instr_memory.sv ====
module instr_memory
    import mips_isa_pkg::*;
(
    input  logic               i_clock,
    input  logic               i_we,
    input  logic [IM_ADDR-1:0] i_waddr,
    input  logic [DWORD-1:0]   i_wdata,
    input  logic [IM_ADDR-1:0] i_raddr,
    output logic [DWORD-1:0]   o_rdata
);

    logic [DWORD-1:0] mem [IMEM_DEPTH];

    // load port, debug unit only
    always_ff @(posedge i_clock) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // async fetch, whole instruction in one cycle
    assign o_rdata = mem[i_raddr];

endmodule

// ==== mips_debug_top.sv ====
module mips_debug_top
    import mips_isa_pkg::*;
(
    input  logic            i_clock,
    input  logic            i_rst_n,
    input  logic [BYTE-1:0] i_rx_data,
    input  logic            i_rx_done,
    input  logic            i_tx_done,
    output logic [BYTE-1:0] o_tx_data,
    output logic            o_tx_start,
    output logic            o_halted
);

    logic               im_write_enable;
    logic [IM_ADDR-1:0] im_addr;
    logic [DWORD-1:0]   im_data;
    logic               core_enable;
    logic               pc_clear;
    logic [RB_ADDR-1:0] rb_addr;
    logic [DWORD-1:0]   pc_value;
    logic [DWORD-1:0]   rb_data;

    // host side, byte strobes from the uart
    debug_unit debug_unit_inst (
        .i_clock           (i_clock),
        .i_rst_n           (i_rst_n),
        .i_rx_data         (i_rx_data),
        .i_rx_done         (i_rx_done),
        .i_tx_done         (i_tx_done),
        .i_halted          (o_halted),
        .i_pc_value        (pc_value),
        .i_rb_data         (rb_data),
        .o_tx_data         (o_tx_data),
        .o_tx_start        (o_tx_start),
        .o_im_write_enable (im_write_enable),
        .o_im_addr         (im_addr),
        .o_im_data         (im_data),
        .o_core_enable     (core_enable),
        .o_pc_clear        (pc_clear),
        .o_rb_addr         (rb_addr)
    );

    // core runs on the same clock, gated by core_enable
    data_path data_path_inst (
        .i_clock           (i_clock),
        .i_rst_n           (i_rst_n),
        .i_core_enable     (core_enable),
        .i_pc_clear        (pc_clear),
        .i_im_write_enable (im_write_enable),
        .i_im_addr         (im_addr),
        .i_im_data         (im_data),
        .i_rb_addr         (rb_addr),
        .o_halted          (o_halted),
        .o_pc_value        (pc_value),
        .o_rb_data         (rb_data)
    );

endmodule

// ==== mips_isa_pkg.sv ====
package mips_isa_pkg;

    // datapath widths
    localparam int DWORD   = 32;
    localparam int BYTE    = 8;
    localparam int RB_ADDR = 5;
    localparam int SHAMT_W = 5;

    // instruction memory, word addressed
    localparam int IMEM_DEPTH = 64;
    localparam int IM_ADDR    = 6;

    // primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0A;
    localparam logic [5:0] OP_ANDI  = 6'h0C;
    localparam logic [5:0] OP_ORI   = 6'h0D;
    localparam logic [5:0] OP_XORI  = 6'h0E;
    localparam logic [5:0] OP_LUI   = 6'h0F;
    // halt is the all-ones word, so its opcode field is all ones too
    localparam logic [5:0] OP_HALT  = 6'h3F;

    // funct field of r-type
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2A;

    // alu operations
    localparam int ALU_OP_W = 4;
    localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SLL = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRL = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_LUI = 4'd8;

    typedef struct packed {
        logic [5:0]         opcode;
        logic [RB_ADDR-1:0] rs;
        logic [RB_ADDR-1:0] rt;
        logic [RB_ADDR-1:0] rd;
        logic [SHAMT_W-1:0] shamt;
        logic [5:0]         funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]         opcode;
        logic [RB_ADDR-1:0] rs;
        logic [RB_ADDR-1:0] rt;
        logic [15:0]        imm16;
    } i_fmt_t;

    // same word seen as r-type or i-type
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

endpackage

// ==== register_bank.sv ====
module register_bank
    import mips_isa_pkg::*;
(
    input  logic               i_clock,
    input  logic               i_rst_n,
    input  logic               i_we,
    input  logic [RB_ADDR-1:0] i_waddr,
    input  logic [DWORD-1:0]   i_wdata,
    input  logic [RB_ADDR-1:0] i_ra,
    input  logic [RB_ADDR-1:0] i_rb,
    input  logic [RB_ADDR-1:0] i_dbg_addr,
    output logic [DWORD-1:0]   o_a,
    output logic [DWORD-1:0]   o_b,
    output logic [DWORD-1:0]   o_dbg
);

    logic [DWORD-1:0] regs [2**RB_ADDR];

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**RB_ADDR; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            // r0 is hardwired, writes to it are dropped
            regs[i_waddr] <= i_wdata;
        end
    end

    // operand ports
    assign o_a = regs[i_ra];
    assign o_b = regs[i_rb];
    // debug readout, combinational from the address
    assign o_dbg = regs[i_dbg_addr];

    // r0 stays zero whatever the core writes
    a_r0_zero: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_we |=> (regs[0] == '0));

endmodule

// ==== result_writeback.sv ====
module result_writeback
    import mips_isa_pkg::*;
(
    input  logic               i_clock,
    input  logic               i_rst_n,
    input  logic               i_enable,
    input  logic               i_clear,
    input  logic               i_reg_write,
    input  logic               i_halt,
    input  logic [RB_ADDR-1:0] i_dest,
    input  logic [DWORD-1:0]   i_result,
    output logic               o_we,
    output logic [RB_ADDR-1:0] o_waddr,
    output logic [DWORD-1:0]   o_wdata,
    output logic               o_halted
);

    // only commit while enabled and not yet halted
    assign o_we    = i_enable && i_reg_write && !o_halted;
    assign o_waddr = i_dest;
    assign o_wdata = i_result;

    // halt flag, held until the debug unit clears it
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            o_halted <= 1'b0;
        end else if (i_clear) begin
            o_halted <= 1'b0;
        end else if (i_enable && i_halt) begin
            o_halted <= 1'b1;
        end
    end

endmodule

// ==== tb_mips_debug_top.sv ====
module tb_mips_debug_top
    import mips_isa_pkg::*;
    import debug_pkg::*;
();

    logic            i_clock;
    logic            i_rst_n;
    logic [BYTE-1:0] i_rx_data;
    logic            i_rx_done;
    logic            i_tx_done;
    logic [BYTE-1:0] o_tx_data;
    logic            o_tx_start;
    logic            o_halted;

    // test table, one slot per entry in each queue
    string            tag_q[$];
    int               cmd_first_q[$];
    int               cmd_len_q[$];
    bit               has_reply_q[$];
    logic [DWORD-1:0] exp_word_q[$];
    bit               wait_halt_q[$];
    logic             exp_halted_q[$];
    logic [BYTE-1:0]  cmd_q[$];

    // bytes returned by the uart model
    logic [BYTE-1:0]  rsp_q[$];
    logic [DWORD-1:0] prog[$];
    logic [DWORD-1:0] model_regs [2**RB_ADDR];
    logic [BYTE-1:0]  tx_byte;
    int               tx_delay;
    int               cmd_mark;
    int               halt_index;
    integer           seed;
    int               cycle_count;
    int               cycle_limit;
    int               tx_start_count;
    int               error_count;
    int               fail_count;
    string            current_tag;

    mips_debug_top mips_debug_top_inst (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_rx_data  (i_rx_data),
        .i_rx_done  (i_rx_done),
        .i_tx_done  (i_tx_done),
        .o_tx_data  (o_tx_data),
        .o_tx_start (o_tx_start),
        .o_halted   (o_halted)
    );

    always #4 i_clock = ~i_clock;

    always @(posedge i_clock) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, test %s never finished", cycle_count, current_tag);
            $display("TEST FAILED");
            $finish;
        end
    end

    // uart side: grab the byte, answer with tx_done after a random wait
    // countdown keeps every negedge free to see the next start pulse
    always @(negedge i_clock) begin
        i_tx_done = 1'b0;
        if (tx_delay > 0) begin
            tx_delay--;
            if (tx_delay == 0) begin
                i_tx_done = 1'b1;
                rsp_q.push_back(tx_byte);
            end
        end
        if (o_tx_start === 1'b1) begin
            tx_byte = o_tx_data;
            tx_start_count++;
            tx_delay = 1 + ($unsigned($random(seed)) % 8);
        end
    end

    function automatic logic [DWORD-1:0] enc_r(logic [RB_ADDR-1:0] rs, logic [RB_ADDR-1:0] rt,
                                               logic [RB_ADDR-1:0] rd, logic [SHAMT_W-1:0] shamt,
                                               logic [5:0] funct);
        instr_u w;
        w.r_fmt.opcode = OP_RTYPE;
        w.r_fmt.rs     = rs;
        w.r_fmt.rt     = rt;
        w.r_fmt.rd     = rd;
        w.r_fmt.shamt  = shamt;
        w.r_fmt.funct  = funct;
        return w;
    endfunction

    function automatic logic [DWORD-1:0] enc_i(logic [5:0] op, logic [RB_ADDR-1:0] rs,
                                               logic [RB_ADDR-1:0] rt, logic [15:0] imm);
        instr_u w;
        w.i_fmt.opcode = op;
        w.i_fmt.rs     = rs;
        w.i_fmt.rt     = rt;
        w.i_fmt.imm16  = imm;
        return w;
    endfunction

    // reference model of one instruction
    function automatic void model_exec(logic [DWORD-1:0] word);
        instr_u           iw;
        logic [DWORD-1:0] a;
        logic [DWORD-1:0] b;
        logic [DWORD-1:0] sext;
        logic [DWORD-1:0] zext;
        logic [DWORD-1:0] value;
        logic             write;
        int               dest;
        iw    = word;
        a     = model_regs[iw.r_fmt.rs];
        b     = model_regs[iw.r_fmt.rt];
        sext  = {{16{iw.i_fmt.imm16[15]}}, iw.i_fmt.imm16};
        zext  = {16'h0000, iw.i_fmt.imm16};
        write = 1'b1;
        dest  = iw.i_fmt.rt;
        value = '0;
        case (iw.r_fmt.opcode)
            OP_RTYPE: begin
                dest = iw.r_fmt.rd;
                case (iw.r_fmt.funct)
                    FN_ADDU: value = a + b;
                    FN_SUBU: value = a - b;
                    FN_AND:  value = a & b;
                    FN_OR:   value = a | b;
                    FN_XOR:  value = a ^ b;
                    FN_SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL:  value = b << iw.r_fmt.shamt;
                    FN_SRL:  value = b >> iw.r_fmt.shamt;
                    default: write = 1'b0;
                endcase
            end
            OP_ADDIU: value = a + sext;
            OP_SLTI:  value = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            OP_ANDI:  value = a & zext;
            OP_ORI:   value = a | zext;
            OP_XORI:  value = a ^ zext;
            OP_LUI:   value = {iw.i_fmt.imm16, 16'h0000};
            default:  write = 1'b0;
        endcase
        if (write && dest != 0) begin
            model_regs[dest] = value;
        end
    endfunction

    // registers after the first n instructions, from a cleared bank
    function automatic void model_run(int n);
        foreach (model_regs[r]) begin
            model_regs[r] = '0;
        end
        for (int i = 0; i < n && i < prog.size(); i++) begin
            if (prog[i] == HALT_WORD) begin
                break;
            end
            model_exec(prog[i]);
        end
    endfunction

    task automatic check_byte(string name, logic [BYTE-1:0] got, logic [BYTE-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("Mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_word(string name, logic [DWORD-1:0] got, logic [DWORD-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            error_count++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // closes an entry over the command bytes queued since the last one
    task automatic add_entry(string tag, bit has_reply, logic [DWORD-1:0] exp_word,
                             bit wait_halt, logic exp_halted);
        tag_q.push_back(tag);
        cmd_first_q.push_back(cmd_mark);
        cmd_len_q.push_back(cmd_q.size() - cmd_mark);
        has_reply_q.push_back(has_reply);
        exp_word_q.push_back(exp_word);
        wait_halt_q.push_back(wait_halt);
        exp_halted_q.push_back(exp_halted);
        cmd_mark = cmd_q.size();
    endtask

    task automatic add_read_reg(int idx, logic [DWORD-1:0] exp, logic halted);
        cmd_q.push_back(CMD_READ_REG);
        cmd_q.push_back(BYTE'(idx));
        add_entry($sformatf("read r%0d", idx), 1'b1, exp, 1'b0, halted);
    endtask

    task automatic add_read_pc(logic [DWORD-1:0] exp, logic halted);
        cmd_q.push_back(CMD_READ_PC);
        add_entry("read pc", 1'b1, exp, 1'b0, halted);
    endtask

    task automatic build_program();
        prog.push_back(enc_i(OP_ADDIU, 0, 1, 16'h1234));
        // negative immediate, sign extended
        prog.push_back(enc_i(OP_ADDIU, 0, 2, 16'hFFF0));
        prog.push_back(enc_i(OP_LUI, 0, 3, 16'hA5A5));
        // logic immediates with bit 15 set, zero extended
        prog.push_back(enc_i(OP_ORI, 3, 4, 16'h8001));
        prog.push_back(enc_i(OP_ANDI, 2, 5, 16'h8F0F));
        prog.push_back(enc_i(OP_XORI, 1, 6, 16'hFFFF));
        prog.push_back(enc_i(OP_SLTI, 2, 7, 16'h0001));
        prog.push_back(enc_r(1, 3, 8, 0, FN_ADDU));
        prog.push_back(enc_r(1, 2, 9, 0, FN_SUBU));
        prog.push_back(enc_r(4, 2, 10, 0, FN_AND));
        prog.push_back(enc_r(1, 6, 11, 0, FN_OR));
        prog.push_back(enc_r(3, 4, 12, 0, FN_XOR));
        prog.push_back(enc_r(1, 2, 13, 0, FN_SLT));
        prog.push_back(enc_r(2, 1, 14, 0, FN_SLT));
        prog.push_back(enc_r(0, 4, 15, 4, FN_SLL));
        prog.push_back(enc_r(0, 4, 16, 8, FN_SRL));
        // write to r0 must be dropped
        prog.push_back(enc_i(OP_ADDIU, 1, 0, 16'h0005));
        prog.push_back(HALT_WORD);
        halt_index = prog.size() - 1;
    endtask

    task automatic build_table();
        add_read_pc(32'd0, 1'b0);
        cmd_q.push_back(CMD_LOAD);
        foreach (prog[i]) begin
            for (int b = 0; b < 4; b++) begin
                cmd_q.push_back(prog[i][b*BYTE +: BYTE]);
            end
        end
        add_entry("load program", 1'b0, '0, 1'b0, 1'b0);
        for (int s = 1; s <= 3; s++) begin
            cmd_q.push_back(CMD_STEP);
            add_entry($sformatf("step %0d", s), 1'b0, '0, 1'b0, 1'b0);
        end
        add_read_pc(32'd12, 1'b0);
        model_run(3);
        for (int r = 1; r <= 3; r++) begin
            add_read_reg(r, model_regs[r], 1'b0);
        end
        cmd_q.push_back(CMD_RUN);
        add_entry("run to halt", 1'b0, '0, 1'b1, 1'b1);
        add_read_pc(4 * halt_index, 1'b1);
        model_run(prog.size());
        for (int r = 0; r <= 16; r++) begin
            add_read_reg(r, model_regs[r], 1'b1);
        end
        // stepping a halted core must not move the pc
        cmd_q.push_back(CMD_STEP);
        add_entry("step while halted", 1'b0, '0, 1'b0, 1'b1);
        add_read_pc(4 * halt_index, 1'b1);
        cmd_q.push_back(CMD_CLEAR);
        add_entry("clear", 1'b0, '0, 1'b0, 1'b0);
        add_read_pc(32'd0, 1'b0);
        cmd_q.push_back(CMD_RUN);
        add_entry("run again", 1'b0, '0, 1'b1, 1'b1);
        add_read_pc(4 * halt_index, 1'b1);
        for (int r = 0; r <= 16; r++) begin
            add_read_reg(r, model_regs[r], 1'b1);
        end
    endtask

    task automatic send_byte(logic [BYTE-1:0] b);
        @(negedge i_clock);
        i_rx_data = b;
        i_rx_done = 1'b1;
        @(negedge i_clock);
        i_rx_done = 1'b0;
        // gap covers the load write cycle
        repeat (2) @(negedge i_clock);
    endtask

    task automatic apply_entry(int idx);
        logic [DWORD-1:0] word;
        logic [BYTE-1:0]  rx;
        int               errors_before;
        current_tag   = tag_q[idx];
        errors_before = error_count;
        rsp_q.delete();
        for (int i = 0; i < cmd_len_q[idx]; i++) begin
            send_byte(cmd_q[cmd_first_q[idx] + i]);
        end
        if (has_reply_q[idx]) begin
            while (rsp_q.size() < 4) begin
                @(negedge i_clock);
            end
            for (int i = 0; i < 4; i++) begin
                rx = rsp_q.pop_front();
                check_byte($sformatf("o_tx_data byte %0d", i), rx,
                           exp_word_q[idx][i*BYTE +: BYTE]);
                word[i*BYTE +: BYTE] = rx;
            end
            check_word("o_tx_data word", word, exp_word_q[idx]);
        end
        if (wait_halt_q[idx]) begin
            while (o_halted !== 1'b1) begin
                @(negedge i_clock);
            end
        end
        repeat (6) @(negedge i_clock);
        if (rsp_q.size() != 0) begin
            error_count++;
            $display("Extra reply bytes were sent during %s", tag_q[idx]);
        end
        check_flag("o_halted", o_halted, exp_halted_q[idx]);
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", idx, tag_q[idx]);
        end else begin
            fail_count++;
            $display("test %0d %s: failed", idx, tag_q[idx]);
        end
    endtask

    initial begin
        i_clock        = 1'b0;
        i_rst_n        = 1'b0;
        i_rx_data      = '0;
        i_rx_done      = 1'b0;
        i_tx_done      = 1'b0;
        seed           = 32'h2d66_066d;
        tx_delay       = 0;
        cycle_count    = 0;
        cycle_limit    = 0;
        cmd_mark       = 0;
        tx_start_count = 0;
        error_count    = 0;
        fail_count     = 0;
        current_tag    = "reset";
        build_program();
        build_table();
        // 40 cycles per table byte, replies are 4 bytes each
        cycle_limit = 2000 + 40 * cmd_q.size();
        foreach (has_reply_q[i]) begin
            cycle_limit += has_reply_q[i] ? 4 * 40 : 0;
        end
        repeat (8) @(negedge i_clock);
        i_rst_n = 1'b1;
        repeat (8) @(negedge i_clock);
        check_flag("o_halted", o_halted, 1'b0);
        if (tx_start_count != 0) begin
            error_count++;
            $display("o_tx_start pulsed after reset with no command");
        end
        $display("test reset: %s", (error_count == 0) ? "ok" : "failed");
        fail_count += (error_count == 0) ? 0 : 1;
        foreach (tag_q[idx]) begin
            apply_entry(idx);
        end
        $display("tests: %0d, failed: %0d, errors: %0d", tag_q.size() + 1, fail_count,
                 error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
mips_isa_pkg.sv
debug_pkg.sv
instr_memory.sv
instr_decoder.sv
register_bank.sv
alu_execute.sv
result_writeback.sv
data_path.sv
debug_unit.sv
mips_debug_top.sv
tb_mips_debug_top.sv
